// ==== rtl/geom_pkg.sv ====
package geom_pkg;

    // pixel coordinate on the 640x480 screen
    typedef logic [9:0] coord_t;

    // ==================================================================
    // screen and grid
    // ==================================================================
    localparam coord_t BLOCK    = 10'd32;
    localparam coord_t SCREEN_W = 10'd640;

    // playable columns, frog is lost outside them
    localparam coord_t PLAY_X_MIN = 10'd96;
    localparam coord_t PLAY_X_MAX = 10'd576;

    // frog home, bottom row centre
    localparam coord_t FROG_START_X = 10'd320;
    localparam coord_t FROG_START_Y = 10'd448;

    // top row counts as home bank
    localparam coord_t GOAL_Y = 10'd32;

    // ==================================================================
    // road
    // ==================================================================
    localparam int     CAR_LANE_COUNT = 6;
    localparam coord_t CAR_LANE_Y0    = 10'd256;
    localparam coord_t CAR_LEN        = 10'd64;
    localparam int     CAR_COUNT      = 7;

    // lane 4 carries two cars, all others one
    localparam coord_t CAR_START_X [CAR_COUNT] = '{
        10'd96, 10'd160, 10'd224, 10'd288, 10'd352, 10'd480, 10'd416
    };
    localparam logic [2:0] CAR_LANE_OF [CAR_COUNT] = '{
        3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd4, 3'd5
    };

endpackage

// ==== rtl/game_pkg.sv ====
package game_pkg;

    // top level game flow
    typedef enum logic [1:0] {
        MENU,
        PLAYING,
        DEAD,
        WON
    } game_state_t;

    // direction of the last jump
    typedef enum logic [1:0] {
        FACE_UP,
        FACE_DOWN,
        FACE_LEFT,
        FACE_RIGHT
    } facing_t;

    // cleared levels in the current run
    typedef logic [3:0] level_t;

endpackage

// ==== rtl/move_if.sv ====
`timescale 1ns/1ps

// one-cycle jump requests, several may fire together
interface move_if;

    logic up;
    logic down;
    logic left;
    logic right;

    modport decoder (output up, output down, output left, output right);

    modport mover (input up, input down, input left, input right);

    modport watcher (input up, input down, input left, input right);

endinterface

// ==== rtl/button_decoder.sv ====
`timescale 1ns/1ps

module button_decoder #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic          osc_25_1M,
    input  logic          rst_n,
    // up, down, left, right from msb down
    input  logic [3:0]    buttons,
    move_if.decoder       moves
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    logic [3:0]    sync_a;
    logic [3:0]    sync_b;
    logic [3:0]    level;
    logic [3:0]    pulse;
    logic [CW-1:0] cnt [4];

    // ==================================================================
    // per button synchroniser, debounce and rise detect
    // ==================================================================
    for (genvar b = 0; b < 4; b++) begin : g_btn
        always_ff @(posedge osc_25_1M or negedge rst_n) begin
            if (!rst_n) begin
                sync_a[b] <= 1'b0;
                sync_b[b] <= 1'b0;
                level[b]  <= 1'b0;
                pulse[b]  <= 1'b0;
                cnt[b]    <= '0;
            end else begin
                sync_a[b] <= buttons[b];
                sync_b[b] <= sync_a[b];
                pulse[b]  <= 1'b0;
                if (sync_b[b] == level[b]) begin
                    // bounce back, start over
                    cnt[b] <= '0;
                end else if (cnt[b] == CW'(DEBOUNCE_CYCLES - 1)) begin
                    level[b] <= sync_b[b];
                    cnt[b]   <= '0;
                    // only a press makes a move
                    pulse[b] <= sync_b[b];
                end else begin
                    cnt[b] <= cnt[b] + CW'(1);
                end
            end
        end
    end

    assign moves.up    = pulse[3];
    assign moves.down  = pulse[2];
    assign moves.left  = pulse[1];
    assign moves.right = pulse[0];

endmodule

// ==== rtl/traffic_lanes.sv ====
`timescale 1ns/1ps

module traffic_lanes
    import geom_pkg::*;
#(
    parameter logic [31:0] CAR_STEP_CYCLES = 32'd200000
) (
    input  logic   osc_25_1M,
    input  logic   rst_n,
    input  coord_t frog_x,
    input  coord_t frog_y,
    output logic   car_hit
);

    logic [31:0]               step_cnt;
    logic                      step;
    coord_t                    car_x [CAR_COUNT];
    logic [CAR_LANE_COUNT-1:0] row_hit;

    // ==================================================================
    // car motion
    // ==================================================================
    assign step = (step_cnt == CAR_STEP_CYCLES - 32'd1);

    always_ff @(posedge osc_25_1M or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
            for (int i = 0; i < CAR_COUNT; i++) begin
                car_x[i] <= CAR_START_X[i];
            end
        end else begin
            step_cnt <= step ? '0 : step_cnt + 32'd1;
            if (step) begin
                for (int i = 0; i < CAR_COUNT; i++) begin
                    // drive off the right edge, reappear at the left
                    if (car_x[i] + 10'd1 == SCREEN_W) begin
                        car_x[i] <= '0;
                    end else begin
                        car_x[i] <= car_x[i] + 10'd1;
                    end
                end
            end
        end
    end

    // ==================================================================
    // overlap test, 11 bit sums avoid wrap
    // ==================================================================
    always_comb begin
        logic [10:0] row_top;
        for (int l = 0; l < CAR_LANE_COUNT; l++) begin
            row_top    = 11'(CAR_LANE_Y0) + 11'(l) * 11'(BLOCK);
            row_hit[l] = (11'(frog_y) < row_top + 11'(BLOCK)) &&
                         (11'(frog_y) + 11'(BLOCK) > row_top);
        end
    end

    always_comb begin
        car_hit = 1'b0;
        for (int i = 0; i < CAR_COUNT; i++) begin
            if (row_hit[CAR_LANE_OF[i]] &&
                (11'(frog_x) < 11'(car_x[i]) + 11'(CAR_LEN)) &&
                (11'(frog_x) + 11'(BLOCK) > 11'(car_x[i]))) begin
                car_hit = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/frog_mover.sv ====
`timescale 1ns/1ps

module frog_mover
    import geom_pkg::*, game_pkg::*;
#(
    parameter logic [31:0] CAR_STEP_CYCLES = 32'd200000
) (
    input  logic        osc_25_1M,
    input  logic        rst_n,
    move_if.mover       moves,
    input  game_state_t state,
    output coord_t      frog_x,
    output coord_t      frog_y,
    output facing_t     facing,
    output logic        hazard,
    output logic        goal
);

    logic car_hit;
    logic off_screen;
    logic send_home;

    traffic_lanes #(
        .CAR_STEP_CYCLES (CAR_STEP_CYCLES)
    ) u_traffic (
        .osc_25_1M (osc_25_1M),
        .rst_n     (rst_n),
        .frog_x    (frog_x),
        .frog_y    (frog_y),
        .car_hit   (car_hit)
    );

    // ==================================================================
    // hazard and goal from the registered position
    // ==================================================================
    // right edge at or left of the verge, or left edge past the far side
    assign off_screen = (11'(frog_x) + 11'(BLOCK) <= 11'(PLAY_X_MIN)) ||
                        (frog_x >= PLAY_X_MAX);

    assign hazard = car_hit || off_screen;
    assign goal   = (frog_y < GOAL_Y);

    // any ending, or not in play at all
    assign send_home = (state != PLAYING) || hazard || goal;

    // ==================================================================
    // grid stepping
    // ==================================================================
    always_ff @(posedge osc_25_1M or negedge rst_n) begin
        if (!rst_n) begin
            frog_x <= FROG_START_X;
            frog_y <= FROG_START_Y;
            facing <= FACE_UP;
        end else if (send_home) begin
            frog_x <= FROG_START_X;
            frog_y <= FROG_START_Y;
            facing <= FACE_UP;
        end else if (moves.up) begin
            frog_y <= frog_y - BLOCK;
            facing <= FACE_UP;
        end else if (moves.down) begin
            frog_y <= frog_y + BLOCK;
            facing <= FACE_DOWN;
        end else if (moves.left) begin
            frog_x <= frog_x - BLOCK;
            facing <= FACE_LEFT;
        end else if (moves.right) begin
            frog_x <= frog_x + BLOCK;
            facing <= FACE_RIGHT;
        end
    end

endmodule

// ==== rtl/game_sequencer.sv ====
`timescale 1ns/1ps

module game_sequencer
    import game_pkg::*;
#(
    parameter int LEVEL_COUNT = 4
) (
    input  logic        osc_25_1M,
    input  logic        rst_n,
    move_if.watcher     moves,
    input  logic        hazard,
    input  logic        goal,
    output game_state_t state,
    output level_t      level,
    output logic        win,
    output logic        lose
);

    logic   any_move;
    level_t next_level;

    assign any_move   = moves.up || moves.down || moves.left || moves.right;
    assign next_level = level + level_t'(1);

    // ==================================================================
    // game FSM with level count
    // ==================================================================
    always_ff @(posedge osc_25_1M or negedge rst_n) begin
        if (!rst_n) begin
            state <= MENU;
            level <= '0;
            win   <= 1'b0;
            lose  <= 1'b0;
        end else begin
            win  <= 1'b0;
            lose <= 1'b0;
            case (state)
                MENU: begin
                    if (any_move) begin
                        state <= PLAYING;
                    end
                end
                PLAYING: begin
                    if (hazard) begin
                        lose  <= 1'b1;
                        state <= DEAD;
                    end else if (goal) begin
                        level <= next_level;
                        // last level cleared
                        if (next_level == level_t'(LEVEL_COUNT)) begin
                            win   <= 1'b1;
                            state <= WON;
                        end
                    end
                end
                default: begin
                    // DEAD or WON, wait for a press to start over
                    if (any_move) begin
                        level <= '0;
                        state <= MENU;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/frogger_top.sv ====
`timescale 1ns/1ps

module frogger_top
    import geom_pkg::*, game_pkg::*;
#(
    parameter int          DEBOUNCE_CYCLES = 250000,
    parameter logic [31:0] CAR_STEP_CYCLES = 32'd200000,
    parameter int          LEVEL_COUNT     = 4
) (
    input  logic        osc_25_1M,
    input  logic        rst_n,
    input  logic        button_up,
    input  logic        button_down,
    input  logic        button_left,
    input  logic        button_right,
    output coord_t      frog_x,
    output coord_t      frog_y,
    output facing_t     facing,
    output game_state_t state,
    output level_t      level,
    output logic        win,
    output logic        lose
);

    logic hazard;
    logic goal;

    move_if moves ();

    // ==================================================================
    // decode, execute, result
    // ==================================================================
    button_decoder #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_decoder (
        .osc_25_1M (osc_25_1M),
        .rst_n     (rst_n),
        .buttons   ({button_up, button_down, button_left, button_right}),
        .moves     (moves.decoder)
    );

    frog_mover #(
        .CAR_STEP_CYCLES (CAR_STEP_CYCLES)
    ) u_mover (
        .osc_25_1M (osc_25_1M),
        .rst_n     (rst_n),
        .moves     (moves.mover),
        .state     (state),
        .frog_x    (frog_x),
        .frog_y    (frog_y),
        .facing    (facing),
        .hazard    (hazard),
        .goal      (goal)
    );

    game_sequencer #(
        .LEVEL_COUNT (LEVEL_COUNT)
    ) u_sequencer (
        .osc_25_1M (osc_25_1M),
        .rst_n     (rst_n),
        .moves     (moves.watcher),
        .hazard    (hazard),
        .goal      (goal),
        .state     (state),
        .level     (level),
        .win       (win),
        .lose      (lose)
    );

endmodule

// ==== sim/frogger_sva.sv ====
`timescale 1ns/1ps

module frogger_sva
    import geom_pkg::*, game_pkg::*;
#(
    parameter int LEVEL_COUNT = 4
) (
    input logic   osc_25_1M,
    input logic   rst_n,
    input coord_t frog_x,
    input coord_t frog_y,
    input level_t level,
    input logic   win,
    input logic   lose
);

    // a run ends one way only
    a_win_lose_excl: assert property (@(posedge osc_25_1M) disable iff (!rst_n)
        !(win && lose))
        else $error("win and lose high in the same cycle");

    a_win_pulse: assert property (@(posedge osc_25_1M) disable iff (!rst_n)
        win |=> !win)
        else $error("win held longer than one cycle");

    a_lose_pulse: assert property (@(posedge osc_25_1M) disable iff (!rst_n)
        lose |=> !lose)
        else $error("lose held longer than one cycle");

    // frog always sits on the grid
    a_grid: assert property (@(posedge osc_25_1M) disable iff (!rst_n)
        ((frog_x % BLOCK) == '0) && ((frog_y % BLOCK) == '0))
        else $error("frog position off the grid");

    a_level: assert property (@(posedge osc_25_1M) disable iff (!rst_n)
        level <= level_t'(LEVEL_COUNT))
        else $error("level above the level count");

endmodule

bind frogger_top frogger_sva #(
    .LEVEL_COUNT (LEVEL_COUNT)
) u_sva (
    .osc_25_1M (osc_25_1M),
    .rst_n     (rst_n),
    .frog_x    (frog_x),
    .frog_y    (frog_y),
    .level     (level),
    .win       (win),
    .lose      (lose)
);

// ==== sim/tb_frogger.sv ====
`timescale 1ns/1ps

module tb_frogger
    import geom_pkg::*, game_pkg::*;
();

    localparam int          DEBOUNCE    = 4;
    localparam logic [31:0] CAR_STEP    = 32'hffff_fff0;
    localparam int          LEVELS      = 2;
    localparam int          HOLD_CYCLES = DEBOUNCE + 8;
    localparam int          WAIT_LIMIT  = 100;

    // bit positions in btn
    localparam int DIR_UP    = 3;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_RIGHT = 0;

    logic        osc_25_1M;
    logic        rst_n;
    logic [3:0]  btn;
    coord_t      frog_x;
    coord_t      frog_y;
    facing_t     facing;
    game_state_t state;
    level_t      level;
    logic        win;
    logic        lose;

    int      errors;
    int      timeouts;
    int      win_count = 0;
    int      lose_count = 0;
    int      jump_mark;
    string   test_name;
    coord_t  exp_x;
    coord_t  exp_y;
    coord_t  last_x;
    coord_t  last_y;
    coord_t  seen_x[$];
    coord_t  seen_y[$];
    facing_t seen_face[$];

    frogger_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .CAR_STEP_CYCLES (CAR_STEP),
        .LEVEL_COUNT     (LEVELS)
    ) UUT (
        .osc_25_1M    (osc_25_1M),
        .rst_n        (rst_n),
        .button_up    (btn[DIR_UP]),
        .button_down  (btn[DIR_DOWN]),
        .button_left  (btn[DIR_LEFT]),
        .button_right (btn[DIR_RIGHT]),
        .frog_x       (frog_x),
        .frog_y       (frog_y),
        .facing       (facing),
        .state        (state),
        .level        (level),
        .win          (win),
        .lose         (lose)
    );

    initial begin
        osc_25_1M = 1'b0;
        forever begin
            #20 osc_25_1M = ~osc_25_1M;
        end
    end

    // log every position change, so one-cycle visits are not missed
    always @(negedge osc_25_1M) begin
        if (!rst_n) begin
            last_x = frog_x;
            last_y = frog_y;
        end else begin
            if (frog_x != last_x || frog_y != last_y) begin
                seen_x.push_back(frog_x);
                seen_y.push_back(frog_y);
                seen_face.push_back(facing);
            end
            last_x = frog_x;
            last_y = frog_y;
            if (win) begin
                win_count++;
            end
            if (lose) begin
                lose_count++;
            end
        end
    end

    // ==================================================================
    // helpers
    // ==================================================================
    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error [%s] %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic press_button(input int dir);
        @(posedge osc_25_1M);
        btn[dir] <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge osc_25_1M);
        btn[dir] <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge osc_25_1M);
    endtask

    task automatic wait_moves(input int count);
        int cycles;
        cycles = 0;
        while (seen_x.size() < count && cycles < WAIT_LIMIT) begin
            @(posedge osc_25_1M);
            cycles++;
        end
        if (seen_x.size() < count) begin
            timeouts++;
            $display("Timeout [%s]: frog position did not change within %0d cycles",
                     test_name, WAIT_LIMIT);
        end
    endtask

    task automatic wait_state(input game_state_t expected);
        int cycles;
        cycles = 0;
        @(negedge osc_25_1M);
        while (state !== expected && cycles < WAIT_LIMIT) begin
            @(negedge osc_25_1M);
            cycles++;
        end
        if (state !== expected) begin
            timeouts++;
            $display("Timeout [%s]: state did not reach %s within %0d cycles",
                     test_name, expected.name(), WAIT_LIMIT);
        end
    endtask

    task automatic check_home();
        check("frog_x home", 32'(FROG_START_X), 32'(frog_x));
        check("frog_y home", 32'(FROG_START_Y), 32'(frog_y));
        exp_x = FROG_START_X;
        exp_y = FROG_START_Y;
    endtask

    // one grid step, checked against where the frog first lands
    task automatic jump(input int dir);
        coord_t  nx;
        coord_t  ny;
        facing_t nf;
        nx = exp_x;
        ny = exp_y;
        nf = FACE_UP;
        case (dir)
            DIR_UP: begin
                ny = exp_y - BLOCK;
            end
            DIR_DOWN: begin
                ny = exp_y + BLOCK;
                nf = FACE_DOWN;
            end
            DIR_LEFT: begin
                nx = exp_x - BLOCK;
                nf = FACE_LEFT;
            end
            default: begin
                nx = exp_x + BLOCK;
                nf = FACE_RIGHT;
            end
        endcase
        jump_mark = seen_x.size();
        press_button(dir);
        wait_moves(jump_mark + 1);
        if (seen_x.size() > jump_mark) begin
            check("frog_x", 32'(nx), 32'(seen_x[jump_mark]));
            check("frog_y", 32'(ny), 32'(seen_y[jump_mark]));
            check("facing", 32'(nf), 32'(seen_face[jump_mark]));
        end
        exp_x = nx;
        exp_y = ny;
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================
    task automatic test_reset();
        int mark;
        test_name = "reset";
        @(negedge osc_25_1M);
        check("state", 32'(MENU), 32'(state));
        check("level", 0, 32'(level));
        check("facing", 32'(FACE_UP), 32'(facing));
        check("win", 0, 32'(win));
        check("lose", 0, 32'(lose));
        check_home();
        // first press only starts the game
        mark = seen_x.size();
        press_button(DIR_LEFT);
        wait_state(PLAYING);
        check("moves in menu", 32'(mark), 32'(seen_x.size()));
        check_home();
    endtask

    task automatic test_steps();
        int base_lose;
        test_name = "steps";
        base_lose = lose_count;
        jump(DIR_RIGHT);
        jump(DIR_UP);
        // back to the start row, then one row below it
        jump(DIR_DOWN);
        jump(DIR_LEFT);
        jump(DIR_DOWN);
        jump(DIR_UP);
        wait_state(PLAYING);
        check("lose pulses", 32'(base_lose), 32'(lose_count));
    endtask

    task automatic test_off_screen();
        int base_lose;
        test_name = "off_screen";
        base_lose = lose_count;
        // x 96 still inside, x 64 is out
        repeat (8) jump(DIR_LEFT);
        wait_state(DEAD);
        check("lose pulses", 32'(base_lose + 1), 32'(lose_count));
        check_home();
        press_button(DIR_UP);
        wait_state(MENU);
    endtask

    task automatic test_collision();
        int base_lose;
        test_name = "collision";
        base_lose = lose_count;
        press_button(DIR_UP);
        wait_state(PLAYING);
        // lane 3 car covers x 288 to 351, frog lands on it at y 352
        repeat (3) jump(DIR_UP);
        wait_state(DEAD);
        check("lose pulses", 32'(base_lose + 1), 32'(lose_count));
        check_home();
        press_button(DIR_DOWN);
        wait_state(MENU);
    endtask

    task automatic test_levels();
        int base_win;
        int base_lose;
        int lvl;
        test_name = "levels";
        base_win = win_count;
        base_lose = lose_count;
        press_button(DIR_UP);
        wait_state(PLAYING);
        for (lvl = 1; lvl <= LEVELS; lvl++) begin
            // column 544 is clear of every car, 14 rows reach y 0
            repeat (7) jump(DIR_RIGHT);
            repeat (14) jump(DIR_UP);
            wait_moves(jump_mark + 2);
            if (seen_x.size() > jump_mark + 1) begin
                check("home x", 32'(FROG_START_X), 32'(seen_x[jump_mark + 1]));
                check("home y", 32'(FROG_START_Y), 32'(seen_y[jump_mark + 1]));
            end
            exp_x = FROG_START_X;
            exp_y = FROG_START_Y;
            if (lvl < LEVELS) begin
                wait_state(PLAYING);
                check("win pulses", 32'(base_win), 32'(win_count));
            end else begin
                wait_state(WON);
                check("win pulses", 32'(base_win + 1), 32'(win_count));
            end
            check("level", 32'(lvl), 32'(level));
        end
        check("lose pulses", 32'(base_lose), 32'(lose_count));
        press_button(DIR_RIGHT);
        wait_state(MENU);
        check("level", 0, 32'(level));
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        errors = 0;
        timeouts = 0;
        jump_mark = 0;
        test_name = "init";
        btn = '0;
        rst_n = 1'b0;
        exp_x = FROG_START_X;
        exp_y = FROG_START_Y;
        repeat (5) @(posedge osc_25_1M);
        rst_n <= 1'b1;

        test_reset();
        test_steps();
        test_off_screen();
        test_collision();
        test_levels();

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/geom_pkg.sv
rtl/game_pkg.sv
rtl/move_if.sv
rtl/button_decoder.sv
rtl/traffic_lanes.sv
rtl/frog_mover.sv
rtl/game_sequencer.sv
rtl/frogger_top.sv
sim/frogger_sva.sv
sim/tb_frogger.sv

// ==== Makefile ====
TOP := tb_frogger
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
